// File: Makefile
# Verilator build and run for the DMA subsystem

VERILATOR ?= verilator
TOP       ?= tb_dma_subsystem
RTL_TOP   ?= dma_subsystem
FLIST     ?= dma_subsystem.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/dma_pkg.sv
// shared widths, device codes and register strobe indices for the DMA engine
// every engine block imports this package inside its body

package dma_pkg;

    // DRAM word address and data word widths
    localparam int addr_w = 21;
    localparam int data_w = 16;

    // width of the device code field in the control byte
    localparam int dev_w = 3;

    // number of register write strobes from the CPU side
    localparam int reg_wr_w = 9;

    // device codes
    localparam logic [dev_w-1:0] dev_ram = 3'd1;
    localparam logic [dev_w-1:0] dev_sd  = 3'd2;
    localparam logic [dev_w-1:0] dev_ide = 3'd3;

    // control byte bit positions, device code sits in bits 2..0
    // wnr: 0 is device to RAM, 1 is RAM to device
    localparam int ctl_wnr   = 7;
    localparam int ctl_salgn = 5;
    localparam int ctl_dalgn = 4;
    localparam int ctl_asz   = 3;

    // strobe indices into reg_wr
    localparam int wr_saddr_l = 0;
    localparam int wr_saddr_h = 1;
    localparam int wr_saddr_x = 2;
    localparam int wr_daddr_l = 3;
    localparam int wr_daddr_h = 4;
    localparam int wr_daddr_x = 5;
    localparam int wr_len     = 6;
    localparam int wr_launch  = 7;
    localparam int wr_num     = 8;

    // data word, seen whole by DRAM and IDE and as two bytes by SD
    typedef union packed {
        logic [data_w-1:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } dma_word_t;

endpackage

// File: dma/dma_addr_gen.sv
// running DRAM address with linear or burst-aligned advance
// one instance for the source, one for the destination

module dma_addr_gen (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        base_load,
    input  logic [dma_pkg::addr_w-1:0]  base,
    input  logic                        step,
    input  logic                        aligned,
    input  logic                        asz,
    input  logic                        next_burst,
    output logic [dma_pkg::addr_w-1:0]  addr
);
    import dma_pkg::*;

    logic [7:0]        low_saved;
    logic [addr_w-9:0] stride;
    logic [addr_w-1:0] addr_next;

    // 256 or 512 words, counted in the upper part
    assign stride = {{(addr_w-10){1'b0}}, asz, ~asz};

    always_comb
    begin
        if (!aligned)
        begin
            addr_next = addr + addr_w'(1);
        end
        else if (next_burst)
        begin
            // back to the loaded low byte, next burst block
            addr_next = {addr[addr_w-1:8] + stride, low_saved};
        end
        else
        begin
            // low byte wraps inside the block
            addr_next = {addr[addr_w-1:8], addr[7:0] + 8'd1};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            addr      <= '0;
            low_saved <= 8'd0;
        end
        else if (base_load)
        begin
            addr      <= base;
            low_saved <= base[7:0];
        end
        else if (step)
        begin
            addr <= addr_next;
        end
    end

endmodule

// File: dma/dma_burst_counter.sv
// word-in-burst and burst counters of the DMA engine
// the ninth burst counter bit marks completion and drives active

module dma_burst_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        launch,
    input  logic        cyc_end,
    input  logic [7:0]  len,
    input  logic [7:0]  num,
    output logic        active,
    output logic        next_burst
);
    import dma_pkg::*;

    logic [7:0] b_ctr;
    logic [8:0] n_ctr;
    logic [7:0] b_ctr_next;
    logic [8:0] n_ctr_next;

    // last word of the current burst
    assign next_burst = (b_ctr == 8'd0);

    assign b_ctr_next = next_burst ? len : b_ctr - 8'd1;
    // underflow of the burst count sets the done bit
    assign n_ctr_next = n_ctr - {8'd0, next_burst};

    assign active = ~n_ctr[8];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            b_ctr <= 8'd0;
            n_ctr <= 9'h100;
        end
        else if (launch)
        begin
            b_ctr <= len;
            n_ctr <= {1'b0, num};
        end
        else if (cyc_end)
        begin
            b_ctr <= b_ctr_next;
            n_ctr <= n_ctr_next;
        end
    end

    a_cyc_end_active: assert property (@(posedge clk) disable iff (!rst_n) cyc_end |-> active)
        else $error("word completed while idle");

endmodule

// File: dma/dma_data_latch.sv
// data word register of the DMA engine
// takes whole words from DRAM or IDE, single bytes from SD

module dma_data_latch (
    input  logic                        clk,
    input  logic                        capture_dram,
    input  logic                        capture_ide,
    input  logic                        capture_sd,
    input  logic                        bsel,
    input  logic [dma_pkg::data_w-1:0]  dram_rddata,
    input  logic [dma_pkg::data_w-1:0]  ide_rddata,
    input  logic [7:0]                  sd_rddata,
    output logic [dma_pkg::data_w-1:0]  word,
    output logic [7:0]                  sd_wrdata
);
    import dma_pkg::*;

    dma_word_t data_q;

    always_ff @(posedge clk)
    begin
        if (capture_dram)
            data_q.word <= dram_rddata;
        else if (capture_ide)
            data_q.word <= ide_rddata;
        else if (capture_sd)
        begin
            // bsel 0 is the low byte, sent first
            if (bsel)
                data_q.bytes.hi <= sd_rddata;
            else
                data_q.bytes.lo <= sd_rddata;
        end
    end

    assign word      = data_q.word;
    assign sd_wrdata = bsel ? data_q.bytes.hi : data_q.bytes.lo;

endmodule

// File: dma/dma_phase_fsm.sv
// read/write phase control of the DMA engine
// picks DRAM or device for each phase and drives the request and direction lines

module dma_phase_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        launch,
    input  logic                        active,
    input  logic [dma_pkg::dev_w-1:0]   device,
    input  logic                        ctl_wnr,
    input  logic                        dram_next,
    input  logic                        sd_stb,
    input  logic                        ide_stb,
    output logic                        phase,
    output logic                        bsel,
    output logic                        phase_end,
    output logic                        cyc_end,
    output logic                        dram_req,
    output logic                        dram_rnw,
    output logic                        sd_req,
    output logic                        sd_rnw,
    output logic                        ide_req,
    output logic                        ide_rnw
);
    import dma_pkg::*;

    logic dv_ram;
    logic dv_sd;
    logic dv_ide;
    logic state_mem;
    logic state_dev;
    logic sd_byte;

    assign dv_ram = (device == dev_ram);
    assign dv_sd  = (device == dev_sd);
    assign dv_ide = (device == dev_ide);

    // RAM to RAM uses DRAM in both phases, otherwise wnr picks the order
    assign state_mem = dv_ram || (ctl_wnr ^ phase);
    assign state_dev = !state_mem;

    assign dram_req = active && state_mem;
    assign sd_req   = active && state_dev && dv_sd;
    assign ide_req  = active && state_dev && dv_ide;

    // phase 0 reads, phase 1 writes
    assign dram_rnw = ~phase;
    assign sd_rnw   = ~phase;
    assign ide_rnw  = ~phase;

    assign sd_byte = sd_req && sd_stb;

    // sd needs both bytes before the phase ends
    assign phase_end = (dram_req && dram_next) || (ide_req && ide_stb) || (sd_byte && bsel);
    assign cyc_end   = phase && phase_end;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase <= 1'b0;
            bsel  <= 1'b0;
        end
        else if (launch)
        begin
            phase <= 1'b0;
            bsel  <= 1'b0;
        end
        else
        begin
            if (phase_end)
                phase <= ~phase;
            // low byte first, back to 0 after the high one
            if (sd_byte)
                bsel <= ~bsel;
        end
    end

    a_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({dram_req, sd_req, ide_req}))
        else $error("more than one request at a time");

    a_stb_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        (!dram_next || dram_req) && (!sd_stb || sd_req) && (!ide_stb || ide_req))
        else $error("strobe without its request");

endmodule

// File: dma/dma_regs.sv
// CPU register port of the DMA engine
// holds addresses, burst length, burst count and control fields, locked while active

module dma_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [dma_pkg::reg_wr_w-1:0]    reg_wr,
    input  logic [7:0]                      reg_wdata,
    input  logic                            active,
    output logic [dma_pkg::addr_w-1:0]      src_base,
    output logic [dma_pkg::addr_w-1:0]      dst_base,
    output logic [7:0]                      len,
    output logic [7:0]                      num,
    output logic                            ctl_wnr,
    output logic                            ctl_salgn,
    output logic                            ctl_dalgn,
    output logic                            ctl_asz,
    output logic [dma_pkg::dev_w-1:0]       device,
    output logic                            launch
);
    import dma_pkg::*;

    logic [reg_wr_w-1:0] wr_en;

    // no register changes while a transfer runs
    assign wr_en  = reg_wr & {reg_wr_w{~active}};
    assign launch = wr_en[wr_launch];

    // address bytes and burst parameters
    always_ff @(posedge clk)
    begin
        if (wr_en[wr_saddr_l])
            src_base[7:0] <= reg_wdata;
        if (wr_en[wr_saddr_h])
            src_base[15:8] <= reg_wdata;
        if (wr_en[wr_saddr_x])
            src_base[addr_w-1:16] <= reg_wdata[addr_w-17:0];
        if (wr_en[wr_daddr_l])
            dst_base[7:0] <= reg_wdata;
        if (wr_en[wr_daddr_h])
            dst_base[15:8] <= reg_wdata;
        if (wr_en[wr_daddr_x])
            dst_base[addr_w-1:16] <= reg_wdata[addr_w-17:0];
        if (wr_en[wr_len])
            len <= reg_wdata;
        if (wr_en[wr_num])
            num <= reg_wdata;
    end

    // control byte, written together with the launch
    // the port names hide the bit positions, so those are taken from the package
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctl_wnr   <= 1'b0;
            ctl_salgn <= 1'b0;
            ctl_dalgn <= 1'b0;
            ctl_asz   <= 1'b0;
            device    <= '0;
        end
        else if (launch)
        begin
            ctl_wnr   <= reg_wdata[dma_pkg::ctl_wnr];
            ctl_salgn <= reg_wdata[dma_pkg::ctl_salgn];
            ctl_dalgn <= reg_wdata[dma_pkg::ctl_dalgn];
            ctl_asz   <= reg_wdata[dma_pkg::ctl_asz];
            device    <= reg_wdata[dev_w-1:0];
        end
    end

    // CPU decoder hands over at most one strobe per cycle
    a_reg_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(reg_wr))
        else $error("reg_wr carries more than one strobe");

endmodule

// File: dma_subsystem.f
common/dma_pkg.sv
dma/dma_regs.sv
dma/dma_phase_fsm.sv
dma/dma_burst_counter.sv
dma/dma_addr_gen.sv
dma/dma_data_latch.sv
verilog/dma_subsystem.sv
testbench/tb_dma_models.sv
testbench/tb_dma_subsystem.sv

// File: testbench/tb_dma_models.sv
// DRAM, SD and IDE responders for the DMA testbench
// each strobe comes after a random wait; sinks and counters are read by the test top

module tb_dma_models (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall_en,
    input  logic [20:0] dram_addr,
    input  logic [15:0] dram_wrdata,
    input  logic        dram_req,
    input  logic        dram_rnw,
    output logic [15:0] dram_rddata,
    output logic        dram_next,
    input  logic [7:0]  sd_wrdata,
    input  logic        sd_req,
    input  logic        sd_rnw,
    output logic [7:0]  sd_rddata,
    output logic        sd_stb,
    input  logic [15:0] ide_wrdata,
    input  logic        ide_req,
    input  logic        ide_rnw,
    output logic [15:0] ide_rddata,
    output logic        ide_stb
);
    timeunit 1ns;
    timeprecision 100ps;

    // only written words are stored, the rest read as the fill pattern
    logic [15:0] mem [int];
    logic [7:0]  sd_sink [0:4095];
    logic [15:0] ide_sink [0:4095];
    int dram_wr_cnt;
    int sd_rd_cnt;
    int sd_wr_cnt;
    int ide_rd_cnt;
    int ide_wr_cnt;
    int dram_wait;
    int sd_wait;
    int ide_wait;

    function automatic logic [15:0] fill_word(logic [20:0] a);
        return a[15:0] ^ {a[20:16], a[20:16], a[20:16], 1'b1};
    endfunction

    function automatic logic [15:0] dram_peek(logic [20:0] a);
        if (mem.exists(int'(a)))
            return mem[int'(a)];
        return fill_word(a);
    endfunction

    function automatic logic [7:0] sd_src_byte(int n);
        return (8'(n) * 8'd29) ^ 8'(n >> 8) ^ 8'h6b;
    endfunction

    function automatic logic [15:0] ide_src_word(int n);
        return (16'(n) * 16'd40503) ^ 16'h1d2c;
    endfunction

    // 0 to 3 cycles, now and then a long stall
    function automatic int pick_wait();
        int w;
        w = $urandom % 4;
        if (stall_en && ($urandom % 8 == 0))
            w = 12;
        return w;
    endfunction

    initial
    begin
        dram_next   = 1'b0;
        sd_stb      = 1'b0;
        ide_stb     = 1'b0;
        dram_rddata = '0;
        sd_rddata   = '0;
        ide_rddata  = '0;
        dram_wr_cnt = 0;
        sd_rd_cnt   = 0;
        sd_wr_cnt   = 0;
        ide_rd_cnt  = 0;
        ide_wr_cnt  = 0;
        dram_wait   = 0;
        sd_wait     = 0;
        ide_wait    = 0;
    end

    // a strobe completes the access at the following edge
    always @(posedge clk)
    begin
        if (!rst_n)
            dram_next <= 1'b0;
        else if (dram_next)
        begin
            if (!dram_rnw)
            begin
                mem[int'(dram_addr)] = dram_wrdata;
                dram_wr_cnt++;
            end
            dram_next <= 1'b0;
            dram_wait <= pick_wait();
        end
        else if (dram_req)
        begin
            if (dram_wait == 0)
            begin
                dram_next   <= 1'b1;
                dram_rddata <= dram_peek(dram_addr);
            end
            else
                dram_wait <= dram_wait - 1;
        end
    end

    always @(posedge clk)
    begin
        if (!rst_n)
            sd_stb <= 1'b0;
        else if (sd_stb)
        begin
            if (!sd_rnw)
            begin
                sd_sink[sd_wr_cnt] = sd_wrdata;
                sd_wr_cnt++;
            end
            else
                sd_rd_cnt++;
            sd_stb  <= 1'b0;
            sd_wait <= pick_wait();
        end
        else if (sd_req)
        begin
            if (sd_wait == 0)
            begin
                sd_stb    <= 1'b1;
                sd_rddata <= sd_src_byte(sd_rd_cnt);
            end
            else
                sd_wait <= sd_wait - 1;
        end
    end

    always @(posedge clk)
    begin
        if (!rst_n)
            ide_stb <= 1'b0;
        else if (ide_stb)
        begin
            if (!ide_rnw)
            begin
                ide_sink[ide_wr_cnt] = ide_wrdata;
                ide_wr_cnt++;
            end
            else
                ide_rd_cnt++;
            ide_stb  <= 1'b0;
            ide_wait <= pick_wait();
        end
        else if (ide_req)
        begin
            if (ide_wait == 0)
            begin
                ide_stb    <= 1'b1;
                ide_rddata <= ide_src_word(ide_rd_cnt);
            end
            else
                ide_wait <= ide_wait - 1;
        end
    end

endmodule

// File: testbench/tb_dma_subsystem.sv
// test top for the DMA engine
// programs random transfers, waits for active to fall and checks sinks and DRAM

module tb_dma_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    // 9 transfers of at most 16 x 8 words
    localparam int max_cycles = 9 * 128 * 10 + 1000;

    logic        clk;
    logic        rst_n;
    logic        stall_en;
    logic [8:0]  reg_wr;
    logic [7:0]  reg_wdata;
    logic        active;
    logic [20:0] dram_addr;
    logic [15:0] dram_rddata;
    logic [15:0] dram_wrdata;
    logic        dram_req;
    logic        dram_rnw;
    logic        dram_next;
    logic [7:0]  sd_rddata;
    logic [7:0]  sd_wrdata;
    logic        sd_req;
    logic        sd_rnw;
    logic        sd_stb;
    logic [15:0] ide_rddata;
    logic [15:0] ide_wrdata;
    logic        ide_req;
    logic        ide_rnw;
    logic        ide_stb;
    logic [2:0]  hold;
    int          errors;
    int          cycles;

    dma_subsystem dut0 (.*);

    tb_dma_models models0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > max_cycles)
        begin
            $display("timeout after %0d cycles, transfer never finished", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // a request waiting for its strobe must still be up
    always @(posedge clk)
    begin
        if (rst_n)
            assert ((hold & ~{dram_req, sd_req, ide_req}) == 3'b000)
            else
            begin
                errors++;
                $display("a request fell before its strobe, mask %b", hold);
            end
        hold <= {dram_req && !dram_next, sd_req && !sd_stb, ide_req && !ide_stb};
    end

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] got);
        assert (exp == got)
        else
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic write_reg(int idx, logic [7:0] val);
        @(posedge clk);
        reg_wr    <= 9'(1) << idx;
        reg_wdata <= val;
        @(posedge clk);
        reg_wr    <= '0;
    endtask

    function automatic logic [20:0] word_addr(logic [20:0] base, logic algn, logic asz,
                                              int len, int k, int i);
        if (algn)
            return {base[20:8] + 13'(k * (asz ? 2 : 1)), base[7:0] + 8'(i)};
        return base + 21'(k * (len + 1) + i);
    endfunction

    task automatic run_test(string name, logic [2:0] dev, logic wnr, logic salgn,
                            logic dalgn, logic asz, logic poke);
        logic [20:0] src;
        logic [20:0] dst;
        logic [15:0] v;
        int len;
        int num;
        int n;
        int dw0;
        int sdr0;
        int sdw0;
        int ider0;
        int idew0;
        bit dram_src;
        bit dram_dst;
        len = poke ? 8 + $urandom % 8 : $urandom % 16;
        num = poke ? 1 + $urandom % 7 : $urandom % 8;
        // source in the lower half, destination in the upper half
        src = 21'($urandom % (1 << 19));
        dst = 21'((1 << 20) + $urandom % (1 << 19));
        dram_src = (dev == 3'd1) || wnr;
        dram_dst = (dev == 3'd1) || !wnr;
        dw0   = models0.dram_wr_cnt;
        sdr0  = models0.sd_rd_cnt;
        sdw0  = models0.sd_wr_cnt;
        ider0 = models0.ide_rd_cnt;
        idew0 = models0.ide_wr_cnt;
        write_reg(0, src[7:0]);
        write_reg(1, src[15:8]);
        write_reg(2, {3'b000, src[20:16]});
        write_reg(3, dst[7:0]);
        write_reg(4, dst[15:8]);
        write_reg(5, {3'b000, dst[20:16]});
        write_reg(6, 8'(len));
        write_reg(8, 8'(num));
        write_reg(7, {wnr, 1'b0, salgn, dalgn, asz, dev});
        @(negedge clk);
        check_val({name, " active"}, 1, active);
        if (poke)
        begin
            // all of these must be ignored, the relaunch too
            for (int j = 0; j < 9; j++)
                write_reg(j, 8'($urandom));
        end
        do
            @(negedge clk);
        while (active);
        for (int k = 0; k <= num; k++)
        begin
            for (int i = 0; i <= len; i++)
            begin
                n = k * (len + 1) + i;
                if (dram_src)
                    v = models0.dram_peek(word_addr(src, salgn, asz, len, k, i));
                else if (dev == 3'd3)
                    v = models0.ide_src_word(ider0 + n);
                else
                    v = {models0.sd_src_byte(sdr0 + 2 * n + 1), models0.sd_src_byte(sdr0 + 2 * n)};
                if (dram_dst)
                    check_val(name, v, models0.dram_peek(word_addr(dst, dalgn, asz, len, k, i)));
                else if (dev == 3'd3)
                    check_val(name, v, models0.ide_sink[idew0 + n]);
                else
                begin
                    check_val({name, " lo"}, v[7:0], models0.sd_sink[sdw0 + 2 * n]);
                    check_val({name, " hi"}, v[15:8], models0.sd_sink[sdw0 + 2 * n + 1]);
                end
            end
        end
        n = (len + 1) * (num + 1);
        // no extra DRAM writes means no other word changed
        check_val({name, " dram writes"}, dram_dst ? n : 0, models0.dram_wr_cnt - dw0);
        if (!dram_dst && dev == 3'd2)
            check_val({name, " sd bytes"}, 2 * n, models0.sd_wr_cnt - sdw0);
        if (!dram_dst && dev == 3'd3)
            check_val({name, " ide words"}, n, models0.ide_wr_cnt - idew0);
    endtask

    initial
    begin
        void'($urandom(32'he154));
        clk       = 1'b0;
        rst_n     = 1'b0;
        stall_en  = 1'b0;
        reg_wr    = '0;
        reg_wdata = '0;
        errors    = 0;
        cycles    = 0;
        hold      = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("reset", 0, {active, dram_req, sd_req, ide_req});
        write_reg(0, 8'h12);
        write_reg(6, 8'h03);
        @(negedge clk);
        check_val("idle writes", 0, {active, dram_req, sd_req, ide_req});

        run_test("ram_lin_a", 3'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("ram_lin_b", 3'd1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("ide_algn_256", 3'd3, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        run_test("ide_algn_512", 3'd3, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        run_test("ram_to_sd", 3'd2, 1'b1, 1'($urandom), 1'b0, 1'($urandom), 1'b0);
        run_test("sd_to_ram", 3'd2, 1'b0, 1'b0, 1'($urandom), 1'($urandom), 1'b0);
        run_test("ram_poke", 3'd1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
        stall_en <= 1'b1;
        run_test("ram_stall", 3'd1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("ram_to_ide_stall", 3'd3, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);

        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog/dma_subsystem.sv
// top level of the DMA engine
// joins the register port, counters, phase FSM, address generators and data latch

module dma_subsystem (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [dma_pkg::reg_wr_w-1:0]    reg_wr,
    input  logic [7:0]                      reg_wdata,
    output logic                            active,
    output logic [dma_pkg::addr_w-1:0]      dram_addr,
    input  logic [dma_pkg::data_w-1:0]      dram_rddata,
    output logic [dma_pkg::data_w-1:0]      dram_wrdata,
    output logic                            dram_req,
    output logic                            dram_rnw,
    input  logic                            dram_next,
    input  logic [7:0]                      sd_rddata,
    output logic [7:0]                      sd_wrdata,
    output logic                            sd_req,
    output logic                            sd_rnw,
    input  logic                            sd_stb,
    input  logic [dma_pkg::data_w-1:0]      ide_rddata,
    output logic [dma_pkg::data_w-1:0]      ide_wrdata,
    output logic                            ide_req,
    output logic                            ide_rnw,
    input  logic                            ide_stb
);
    import dma_pkg::*;

    logic [addr_w-1:0] src_base;
    logic [addr_w-1:0] dst_base;
    logic [addr_w-1:0] src_addr;
    logic [addr_w-1:0] dst_addr;
    logic [7:0]        len;
    logic [7:0]        num;
    logic              ctl_wnr;
    logic              ctl_salgn;
    logic              ctl_dalgn;
    logic              ctl_asz;
    logic [dev_w-1:0]  device;
    logic              launch;
    logic              next_burst;
    logic              phase;
    logic              bsel;
    logic              phase_end;
    logic              cyc_end;
    logic              capture_dram;
    logic              capture_ide;
    logic              capture_sd;
    logic [data_w-1:0] word;

    // read phase strobes load the data latch
    assign capture_dram = dram_req && dram_rnw && dram_next;
    assign capture_ide  = ide_req && ide_rnw && ide_stb;
    assign capture_sd   = sd_req && sd_rnw && sd_stb;

    assign dram_addr   = phase ? dst_addr : src_addr;
    assign dram_wrdata = word;
    assign ide_wrdata  = word;

    dma_regs regs0 (
        .clk(clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_wdata(reg_wdata),
        .active(active), .src_base(src_base), .dst_base(dst_base),
        .len(len), .num(num), .ctl_wnr(ctl_wnr), .ctl_salgn(ctl_salgn),
        .ctl_dalgn(ctl_dalgn), .ctl_asz(ctl_asz), .device(device), .launch(launch)
    );

    dma_burst_counter cnt0 (
        .clk(clk), .rst_n(rst_n), .launch(launch), .cyc_end(cyc_end),
        .len(len), .num(num), .active(active), .next_burst(next_burst)
    );

    dma_phase_fsm fsm0 (
        .clk(clk), .rst_n(rst_n), .launch(launch), .active(active),
        .device(device), .ctl_wnr(ctl_wnr), .dram_next(dram_next),
        .sd_stb(sd_stb), .ide_stb(ide_stb), .phase(phase), .bsel(bsel),
        .phase_end(phase_end), .cyc_end(cyc_end),
        .dram_req(dram_req), .dram_rnw(dram_rnw), .sd_req(sd_req),
        .sd_rnw(sd_rnw), .ide_req(ide_req), .ide_rnw(ide_rnw)
    );

    // source steps at the end of read phases
    dma_addr_gen src_gen (
        .clk(clk), .rst_n(rst_n), .base_load(launch), .base(src_base),
        .step(phase_end && !phase), .aligned(ctl_salgn), .asz(ctl_asz),
        .next_burst(next_burst), .addr(src_addr)
    );

    // destination steps at the end of write phases
    dma_addr_gen dst_gen (
        .clk(clk), .rst_n(rst_n), .base_load(launch), .base(dst_base),
        .step(cyc_end), .aligned(ctl_dalgn), .asz(ctl_asz),
        .next_burst(next_burst), .addr(dst_addr)
    );

    dma_data_latch latch0 (
        .clk(clk), .capture_dram(capture_dram), .capture_ide(capture_ide),
        .capture_sd(capture_sd), .bsel(bsel), .dram_rddata(dram_rddata),
        .ide_rddata(ide_rddata), .sd_rddata(sd_rddata),
        .word(word), .sd_wrdata(sd_wrdata)
    );

endmodule
